//--- mgmt_subsystem.f
mgmt_pkg.sv
apb_reg_slice.sv
apb_block_decoder.sv
fan_tachometer.sv
sysinfo_regs.sv
spi_host.sv
frontpanel_regs.sv
mgmt_subsystem.sv
mgmt_subsystem_tb.sv

//--- mgmt_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mgmt_subsystem_tb;

	localparam int clk_period = 8;
	localparam int reset_cycles = 16;
	localparam int tach0_period = 40;
	localparam int tach1_period = 64;
	// One SPI byte, 16 half periods plus start and done
	localparam int spi_byte_cycles = 16 * mgmt_pkg::spi_clk_div + 2;
	// Run is about 6600 cycles, so this leaves a wide margin
	localparam int watchdog_ns = 25000 * clk_period;

	logic sys_clk = 1'b0;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	mgmt_pkg::apb_addr_t paddr;
	mgmt_pkg::apb_data_t pwdata;
	mgmt_pkg::apb_data_t prdata;
	logic pready;
	logic pslverr;
	logic [1:0] fan_tach;
	mgmt_pkg::idcode_t idcode;
	logic frontpanel_sck;
	logic frontpanel_mosi;
	logic frontpanel_miso;
	logic frontpanel_cs_n;

	// Expected register contents
	mgmt_pkg::apb_data_t scratch_model;
	logic cs_model;
	logic busy_model;
	mgmt_pkg::spi_byte_t last_sent;
	mgmt_pkg::spi_byte_t echo_byte;

	logic [15:0] lfsr;
	int err_count;
	int check_count;

	// Completed reads waiting for the compare process
	mgmt_pkg::apb_addr_t chk_addr_q[$];
	mgmt_pkg::apb_data_t chk_data_q[$];
	logic chk_err_q[$];
	mgmt_pkg::apb_data_t exp_data_q[$];
	logic exp_err_q[$];

	always #(clk_period / 2) sys_clk = ~sys_clk;

	mgmt_subsystem i_dut(
		.sys_clk(sys_clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.fan_tach(fan_tach),
		.idcode(idcode),
		.frontpanel_sck(frontpanel_sck),
		.frontpanel_mosi(frontpanel_mosi),
		.frontpanel_miso(frontpanel_miso),
		.frontpanel_cs_n(frontpanel_cs_n)
	);

	//////////////////////////////////////////////////
	// SPI echo device and fan tach sources

	mgmt_pkg::spi_byte_t dev_sr;
	logic sck_prev;
	int tach0_cnt;
	int tach1_cnt;

	// Shift on SCK rise while selected, MSB goes back out on miso
	always @(posedge sys_clk) begin : spi_device
		mgmt_pkg::spi_byte_t sr_next;
		sr_next = dev_sr;
		if (frontpanel_sck && !sck_prev && !frontpanel_cs_n)
			sr_next = {dev_sr[6:0], frontpanel_mosi};
		sck_prev <= frontpanel_sck;
		dev_sr <= sr_next;
		frontpanel_miso <= frontpanel_cs_n ? 1'b0 : sr_next[7];
	end

	// Square waves, half high and half low
	always @(posedge sys_clk) begin
		tach0_cnt <= (tach0_cnt == tach0_period - 1) ? 0 : tach0_cnt + 1;
		tach1_cnt <= (tach1_cnt == tach1_period - 1) ? 0 : tach1_cnt + 1;
		fan_tach[0] <= (tach0_cnt < tach0_period / 2);
		fan_tach[1] <= (tach1_cnt < tach1_period / 2);
	end

	//////////////////////////////////////////////////
	// Random source and reference

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// Value a read should return, from the register map
	function automatic mgmt_pkg::apb_data_t expected_read(input mgmt_pkg::apb_addr_t addr);
		mgmt_pkg::dev_addr_t off;
		off = addr[mgmt_pkg::block_addr_bits-1:0];
		expected_read = '0;
		if (addr < 24'h400) begin
			case (off)
				mgmt_pkg::reg_idcode_lo: expected_read = idcode[15:0];
				mgmt_pkg::reg_idcode_hi: expected_read = idcode[31:16];
				mgmt_pkg::reg_fan0:
					expected_read = 16'(mgmt_pkg::tach_window_cycles / tach0_period);
				mgmt_pkg::reg_fan1:
					expected_read = 16'(mgmt_pkg::tach_window_cycles / tach1_period);
				mgmt_pkg::reg_scratch: expected_read = scratch_model;
				default: expected_read = '0;
			endcase
		end else if (addr < 24'h800) begin
			// Busy follows the transfer model
			case (off)
				mgmt_pkg::reg_fp_ctrl: expected_read = {15'h0, cs_model};
				mgmt_pkg::reg_fp_data: expected_read = {8'h0, echo_byte};
				mgmt_pkg::reg_fp_status: expected_read = {15'h0, busy_model};
				default: expected_read = '0;
			endcase
		end
	endfunction

	//////////////////////////////////////////////////
	// APB requester

	task automatic apb_xfer(input logic write, input mgmt_pkg::apb_addr_t addr,
			input mgmt_pkg::apb_data_t wdata, output mgmt_pkg::apb_data_t rdata,
			output logic err, output int waits);
		waits = 0;
		@(posedge sys_clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge sys_clk);
		penable <= 1'b1;
		// Response sampled mid-cycle
		do begin
			@(negedge sys_clk);
			waits++;
		end while (!pready);
		rdata = prdata;
		err = pslverr;
		@(posedge sys_clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic write_reg(input mgmt_pkg::apb_addr_t addr, input mgmt_pkg::apb_data_t data,
			output int waits);
		mgmt_pkg::apb_data_t d;
		logic e;
		apb_xfer(1'b1, addr, data, d, e, waits);
		check_count++;
		if (e !== (addr >= 24'h800)) begin
			err_count++;
			$display("[FAIL] %0t ns: write to 0x%06h gave pslverr %0b", $time, addr, e);
		end
	endtask

	// Queue the read result with its expectation
	task automatic check_read(input mgmt_pkg::apb_addr_t addr);
		mgmt_pkg::apb_data_t d;
		logic e;
		int w;
		apb_xfer(1'b0, addr, '0, d, e, w);
		chk_addr_q.push_back(addr);
		chk_data_q.push_back(d);
		chk_err_q.push_back(e);
		exp_data_q.push_back(expected_read(addr));
		exp_err_q.push_back(addr >= 24'h800);
	endtask

	task automatic wait_spi_idle();
		mgmt_pkg::apb_data_t d;
		logic e;
		int w;
		do begin
			apb_xfer(1'b0, 24'h400 + mgmt_pkg::reg_fp_status, '0, d, e, w);
		end while (d[0]);
	endtask

	task automatic check_pin(input logic got, input logic exp, input string what);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("[FAIL] %0t ns: %s is %0b, expected %0b", $time, what, got, exp);
		end
	endtask

	task automatic check_waits(input int got, input int lo, input int hi, input string what);
		check_count++;
		if (got < lo || got > hi) begin
			err_count++;
			$display("[FAIL] %0t ns: %s took %0d cycles, expected %0d to %0d",
				$time, what, got, lo, hi);
		end
	endtask

	//////////////////////////////////////////////////
	// Compare process

	always @(posedge sys_clk) begin : compare
		mgmt_pkg::apb_addr_t a;
		mgmt_pkg::apb_data_t got;
		mgmt_pkg::apb_data_t exp;
		logic got_err;
		logic exp_err;
		logic tach_reg;
		int diff;
		if (chk_addr_q.size() > 0) begin
			a = chk_addr_q.pop_front();
			got = chk_data_q.pop_front();
			got_err = chk_err_q.pop_front();
			exp = exp_data_q.pop_front();
			exp_err = exp_err_q.pop_front();
			check_count++;
			// Fan counts may land one edge either way
			tach_reg = (a == mgmt_pkg::reg_fan0) || (a == mgmt_pkg::reg_fan1);
			diff = int'(got) - int'(exp);
			if (got_err !== exp_err) begin
				err_count++;
				$display("[FAIL] %0t ns: read 0x%06h pslverr %0b, expected %0b",
					$time, a, got_err, exp_err);
			end
			if (tach_reg) begin
				if (diff > 1 || diff < -1) begin
					err_count++;
					$display("[FAIL] %0t ns: fan count at 0x%06h is %0d, expected %0d",
						$time, a, got, exp);
				end
			end else if (got !== exp) begin
				err_count++;
				$display("[FAIL] %0t ns: read 0x%06h gave 0x%04h, expected 0x%04h",
					$time, a, got, exp);
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus

	initial begin : stimulus
		logic [31:0] r;
		int w;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		fan_tach = 2'b00;
		frontpanel_miso = 1'b0;
		tach0_cnt = 0;
		tach1_cnt = 0;
		dev_sr = '0;
		sck_prev = 1'b0;
		err_count = 0;
		check_count = 0;
		scratch_model = '0;
		cs_model = 1'b1;
		busy_model = 1'b0;
		last_sent = '0;
		echo_byte = '0;
		lfsr = 16'd26;
		take_bits(32, r);
		idcode = r;

		repeat (reset_cycles) @(posedge sys_clk);
		rst <= 1'b0;
		@(negedge sys_clk);

		// Reset state
		check_pin(frontpanel_cs_n, 1'b1, "frontpanel_cs_n");
		check_pin(frontpanel_sck, 1'b0, "frontpanel_sck");
		check_pin(frontpanel_mosi, 1'b0, "frontpanel_mosi");
		check_pin(pready, 1'b0, "pready");
		check_read(mgmt_pkg::reg_scratch);
		check_read(24'h400 + mgmt_pkg::reg_fp_status);

		// ID code, scratch and holes in the map
		check_read(mgmt_pkg::reg_idcode_lo);
		check_read(mgmt_pkg::reg_idcode_hi);
		repeat (4) begin
			take_bits(16, r);
			write_reg(mgmt_pkg::reg_scratch, r[15:0], w);
			scratch_model = r[15:0];
			check_waits(w, 2, 2, "scratch write");
			check_read(mgmt_pkg::reg_scratch);
		end
		check_read(24'h00A);
		check_read(24'h3FE);
		check_read(24'h406);

		// Select the panel
		write_reg(24'h400 + mgmt_pkg::reg_fp_ctrl, 16'h0000, w);
		cs_model = 1'b0;
		@(negedge sys_clk);
		check_pin(frontpanel_cs_n, 1'b0, "frontpanel_cs_n");
		check_read(24'h400 + mgmt_pkg::reg_fp_ctrl);

		// Two bytes back to back, the second one stalls
		take_bits(8, r);
		write_reg(24'h400 + mgmt_pkg::reg_fp_data, {8'h0, r[7:0]}, w);
		echo_byte = last_sent;
		last_sent = r[7:0];
		check_waits(w, 2, 2, "first data write");
		take_bits(8, r);
		write_reg(24'h400 + mgmt_pkg::reg_fp_data, {8'h0, r[7:0]}, w);
		echo_byte = last_sent;
		last_sent = r[7:0];
		check_waits(w, 3, spi_byte_cycles + 4, "stalled data write");
		wait_spi_idle();
		check_read(24'h400 + mgmt_pkg::reg_fp_data);

		// Third byte brings back the second
		// Status shows busy while it shifts
		take_bits(8, r);
		write_reg(24'h400 + mgmt_pkg::reg_fp_data, {8'h0, r[7:0]}, w);
		echo_byte = last_sent;
		last_sent = r[7:0];
		busy_model = 1'b1;
		check_read(24'h400 + mgmt_pkg::reg_fp_status);
		wait_spi_idle();
		busy_model = 1'b0;
		check_read(24'h400 + mgmt_pkg::reg_fp_data);

		write_reg(24'h400 + mgmt_pkg::reg_fp_ctrl, 16'h0001, w);
		cs_model = 1'b1;
		@(negedge sys_clk);
		check_pin(frontpanel_cs_n, 1'b1, "frontpanel_cs_n");

		// Let three gate windows pass
		repeat (3 * mgmt_pkg::tach_window_cycles) @(posedge sys_clk);
		check_read(mgmt_pkg::reg_fan0);
		check_read(mgmt_pkg::reg_fan1);

		// Unmapped blocks
		check_read(24'h800);
		check_read(24'hFFFFFE);
		write_reg(24'h800, 16'hA5A5, w);

		repeat (4) @(posedge sys_clk);
		$display("Checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(watchdog_ns);
		$display("Timeout: the run did not finish within %0d ns", watchdog_ns);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- mgmt_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mgmt_subsystem(
	input wire sys_clk,
	input wire rst,

	// APB completer port
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire mgmt_pkg::apb_addr_t paddr,
	input wire mgmt_pkg::apb_data_t pwdata,
	output mgmt_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,

	// Fan tach inputs and device ID
	input wire [1:0] fan_tach,
	input wire mgmt_pkg::idcode_t idcode,

	// Front panel SPI
	output logic frontpanel_sck,
	output logic frontpanel_mosi,
	input wire frontpanel_miso,
	output logic frontpanel_cs_n
);

	//////////////////////////////////////////////////
	// Registered request path into the decoder

	wire slc_psel;
	wire slc_penable;
	wire slc_pwrite;
	wire mgmt_pkg::apb_addr_t slc_paddr;
	wire mgmt_pkg::apb_data_t slc_pwdata;
	wire mgmt_pkg::apb_data_t slc_prdata;
	wire slc_pready;
	wire slc_pslverr;

	apb_reg_slice i_slice(
		.sys_clk(sys_clk),
		.rst(rst),
		.up_psel(psel),
		.up_penable(penable),
		.up_pwrite(pwrite),
		.up_paddr(paddr),
		.up_pwdata(pwdata),
		.up_prdata(prdata),
		.up_pready(pready),
		.up_pslverr(pslverr),
		.dn_psel(slc_psel),
		.dn_penable(slc_penable),
		.dn_pwrite(slc_pwrite),
		.dn_paddr(slc_paddr),
		.dn_pwdata(slc_pwdata),
		.dn_prdata(slc_prdata),
		.dn_pready(slc_pready),
		.dn_pslverr(slc_pslverr)
	);

	//////////////////////////////////////////////////
	// Block decoder, 0x000 sysinfo and 0x400 front panel

	wire [mgmt_pkg::num_blocks-1:0] dev_psel;
	wire dev_penable;
	wire dev_pwrite;
	wire mgmt_pkg::dev_addr_t dev_paddr;
	wire mgmt_pkg::apb_data_t dev_pwdata;
	wire mgmt_pkg::apb_data_t dev_prdata [mgmt_pkg::num_blocks];
	wire [mgmt_pkg::num_blocks-1:0] dev_pready;
	wire [mgmt_pkg::num_blocks-1:0] dev_pslverr;

	apb_block_decoder i_decoder(
		.psel(slc_psel),
		.penable(slc_penable),
		.pwrite(slc_pwrite),
		.paddr(slc_paddr),
		.pwdata(slc_pwdata),
		.prdata(slc_prdata),
		.pready(slc_pready),
		.pslverr(slc_pslverr),
		.dev_psel(dev_psel),
		.dev_penable(dev_penable),
		.dev_pwrite(dev_pwrite),
		.dev_paddr(dev_paddr),
		.dev_pwdata(dev_pwdata),
		.dev_prdata(dev_prdata),
		.dev_pready(dev_pready),
		.dev_pslverr(dev_pslverr)
	);

	// Fan tachometers
	wire mgmt_pkg::tach_count_t fan0_count;
	wire mgmt_pkg::tach_count_t fan1_count;

	fan_tachometer i_tach0(
		.sys_clk(sys_clk),
		.rst(rst),
		.tach(fan_tach[0]),
		.count(fan0_count)
	);

	fan_tachometer i_tach1(
		.sys_clk(sys_clk),
		.rst(rst),
		.tach(fan_tach[1]),
		.count(fan1_count)
	);

	sysinfo_regs i_sysinfo(
		.sys_clk(sys_clk),
		.rst(rst),
		.psel(dev_psel[0]),
		.penable(dev_penable),
		.pwrite(dev_pwrite),
		.paddr(dev_paddr),
		.pwdata(dev_pwdata),
		.prdata(dev_prdata[0]),
		.pready(dev_pready[0]),
		.pslverr(dev_pslverr[0]),
		.fan0_count(fan0_count),
		.fan1_count(fan1_count),
		.idcode(idcode)
	);

	frontpanel_regs i_frontpanel(
		.sys_clk(sys_clk),
		.rst(rst),
		.psel(dev_psel[1]),
		.penable(dev_penable),
		.pwrite(dev_pwrite),
		.paddr(dev_paddr),
		.pwdata(dev_pwdata),
		.prdata(dev_prdata[1]),
		.pready(dev_pready[1]),
		.pslverr(dev_pslverr[1]),
		.sck(frontpanel_sck),
		.mosi(frontpanel_mosi),
		.miso(frontpanel_miso),
		.cs_n(frontpanel_cs_n)
	);

endmodule

`default_nettype wire

//--- frontpanel_regs.sv
`timescale 1ns/1ps
`default_nettype none

module frontpanel_regs(
	input wire sys_clk,
	input wire rst,

	// APB completer
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire mgmt_pkg::dev_addr_t paddr,
	input wire mgmt_pkg::apb_data_t pwdata,
	output mgmt_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,

	// Front panel SPI pins
	output logic sck,
	output logic mosi,
	input wire miso,
	output logic cs_n
);

	mgmt_pkg::spi_byte_t rx_byte;
	logic busy;
	logic start;

	logic access;
	logic wr_data;
	logic rd_setup;

	assign access = psel && penable;
	assign wr_data = access && pwrite && (paddr == mgmt_pkg::reg_fp_data);
	assign rd_setup = psel && !penable && !pwrite;

	// Data write waits for the current byte to finish
	assign pready = access && !(wr_data && busy);
	assign pslverr = 1'b0;

	// Shift starts on the same cycle the write completes
	assign start = wr_data && !busy;

	//////////////////////////////////////////////////
	// Chip select

	always_ff @(posedge sys_clk) begin
		if (rst)
			cs_n <= 1'b1;
		else if (access && pwrite && (paddr == mgmt_pkg::reg_fp_ctrl))
			cs_n <= pwdata[0];
	end

	// Read mux, fetched in the setup cycle
	always_ff @(posedge sys_clk) begin
		if (rst) begin
			prdata <= '0;
		end else if (rd_setup) begin
			case (paddr)
				mgmt_pkg::reg_fp_ctrl: prdata <= {15'h0, cs_n};
				mgmt_pkg::reg_fp_data: prdata <= {8'h0, rx_byte};
				mgmt_pkg::reg_fp_status: prdata <= {15'h0, busy};
				default: prdata <= '0;
			endcase
		end
	end

	spi_host i_spi(
		.sys_clk(sys_clk),
		.rst(rst),
		.start(start),
		.tx_byte(pwdata[7:0]),
		.rx_byte(rx_byte),
		.busy(busy),
		.sck(sck),
		.mosi(mosi),
		.miso(miso)
	);

endmodule

`default_nettype wire

//--- spi_host.sv
`timescale 1ns/1ps
`default_nettype none

module spi_host(
	input wire sys_clk,
	input wire rst,

	// Byte interface
	input wire start,
	input wire mgmt_pkg::spi_byte_t tx_byte,
	output mgmt_pkg::spi_byte_t rx_byte,
	output logic busy,

	// SPI pins, mode 0
	output logic sck,
	output logic mosi,
	input wire miso
);

	mgmt_pkg::spi_state_t state;
	mgmt_pkg::spi_div_t div_cnt;
	mgmt_pkg::spi_bit_t bit_cnt;
	mgmt_pkg::spi_byte_t tx_sr;
	mgmt_pkg::spi_byte_t rx_sr;
	logic half_end;

	// Last sys_clk cycle of an SCK half period
	assign half_end = (div_cnt == mgmt_pkg::spi_div_t'(mgmt_pkg::spi_clk_div - 1));

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			state <= mgmt_pkg::idle;
			busy <= 1'b0;
			sck <= 1'b0;
			mosi <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			case (state)
				mgmt_pkg::idle: begin
					div_cnt <= '0;
					if (start) begin
						// MSB goes out ahead of the first rising edge
						tx_sr <= tx_byte;
						mosi <= tx_byte[7];
						bit_cnt <= '0;
						busy <= 1'b1;
						state <= mgmt_pkg::shift_low;
					end
				end
				mgmt_pkg::shift_low: begin
					if (half_end) begin
						// Rising edge, miso is still the value before the edge
						sck <= 1'b1;
						rx_sr <= {rx_sr[6:0], miso};
						state <= mgmt_pkg::shift_high;
					end
				end
				mgmt_pkg::shift_high: begin
					if (half_end) begin
						sck <= 1'b0;
						if (bit_cnt == 3'd7) begin
							state <= mgmt_pkg::done_st;
						end else begin
							// Next bit changes with the falling edge
							tx_sr <= {tx_sr[6:0], 1'b0};
							mosi <= tx_sr[6];
							bit_cnt <= bit_cnt + 1'b1;
							state <= mgmt_pkg::shift_low;
						end
					end
				end
				mgmt_pkg::done_st: begin
					busy <= 1'b0;
					state <= mgmt_pkg::idle;
				end
				default: state <= mgmt_pkg::idle;
			endcase
		end
	end

	// Received byte only updates once the whole byte is in
	always_ff @(posedge sys_clk) begin
		if (rst)
			rx_byte <= '0;
		else if (state == mgmt_pkg::done_st)
			rx_byte <= rx_sr;
	end

endmodule

`default_nettype wire

//--- sysinfo_regs.sv
`timescale 1ns/1ps
`default_nettype none

module sysinfo_regs(
	input wire sys_clk,
	input wire rst,

	// APB completer
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire mgmt_pkg::dev_addr_t paddr,
	input wire mgmt_pkg::apb_data_t pwdata,
	output mgmt_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,

	// Status inputs
	input wire mgmt_pkg::tach_count_t fan0_count,
	input wire mgmt_pkg::tach_count_t fan1_count,
	input wire mgmt_pkg::idcode_t idcode
);

	// Read data is fetched in the setup cycle
	logic rd_setup;
	logic wr_access;

	assign rd_setup = psel && !penable && !pwrite;
	assign wr_access = psel && penable && pwrite;

	// No wait states and no error offsets in this block
	assign pready = psel && penable;
	assign pslverr = 1'b0;

	//////////////////////////////////////////////////
	// Scratch register

	mgmt_pkg::apb_data_t scratch;

	always_ff @(posedge sys_clk) begin
		if (rst)
			scratch <= '0;
		else if (wr_access && (paddr == mgmt_pkg::reg_scratch))
			scratch <= pwdata;
	end

	//////////////////////////////////////////////////
	// Read mux

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			prdata <= '0;
		end else if (rd_setup) begin
			case (paddr)
				mgmt_pkg::reg_idcode_lo: prdata <= idcode[15:0];
				mgmt_pkg::reg_idcode_hi: prdata <= idcode[31:16];
				mgmt_pkg::reg_fan0: prdata <= fan0_count;
				mgmt_pkg::reg_fan1: prdata <= fan1_count;
				mgmt_pkg::reg_scratch: prdata <= scratch;
				// Holes in the map read as zero
				default: prdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- fan_tachometer.sv
`timescale 1ns/1ps
`default_nettype none

module fan_tachometer(
	input wire sys_clk,
	input wire rst,
	input wire tach,
	output mgmt_pkg::tach_count_t count
);

	// Two stage synchronizer plus edge history
	logic [1:0] tach_sync;
	logic tach_prev;
	logic tach_rise;

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			tach_sync <= 2'b00;
			tach_prev <= 1'b0;
		end else begin
			tach_sync <= {tach_sync[0], tach};
			tach_prev <= tach_sync[1];
		end
	end

	assign tach_rise = tach_sync[1] && !tach_prev;

	//////////////////////////////////////////////////
	// Gate window and edge count

	mgmt_pkg::window_cnt_t window_cnt;
	mgmt_pkg::tach_count_t edge_cnt;
	logic window_end;

	assign window_end =
		(window_cnt == mgmt_pkg::window_cnt_t'(mgmt_pkg::tach_window_cycles - 1));

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			window_cnt <= '0;
			edge_cnt <= '0;
			count <= '0;
		end else if (window_end) begin
			// Edge in the last cycle still belongs to this window
			window_cnt <= '0;
			edge_cnt <= '0;
			count <= edge_cnt + mgmt_pkg::tach_count_t'(tach_rise);
		end else begin
			window_cnt <= window_cnt + 1'b1;
			if (tach_rise)
				edge_cnt <= edge_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- apb_block_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module apb_block_decoder(
	// Upstream side
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire mgmt_pkg::apb_addr_t paddr,
	input wire mgmt_pkg::apb_data_t pwdata,
	output mgmt_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,

	// Device side, one select per block and shared request fields
	output logic [mgmt_pkg::num_blocks-1:0] dev_psel,
	output logic dev_penable,
	output logic dev_pwrite,
	output mgmt_pkg::dev_addr_t dev_paddr,
	output mgmt_pkg::apb_data_t dev_pwdata,
	input wire mgmt_pkg::apb_data_t dev_prdata [mgmt_pkg::num_blocks],
	input wire [mgmt_pkg::num_blocks-1:0] dev_pready,
	input wire [mgmt_pkg::num_blocks-1:0] dev_pslverr
);

	// Block number sits above the in-block offset
	mgmt_pkg::blk_sel_t blk;
	logic hit;

	assign blk = paddr[mgmt_pkg::apb_addr_bits-1:mgmt_pkg::block_addr_bits];
	assign hit = (blk < mgmt_pkg::num_blocks);

	//////////////////////////////////////////////////
	// Request fan-out

	assign dev_penable = penable;
	assign dev_pwrite = pwrite;
	assign dev_paddr = paddr[mgmt_pkg::block_addr_bits-1:0];
	assign dev_pwdata = pwdata;

	always_comb begin
		for (int i = 0; i < mgmt_pkg::num_blocks; i++) begin
			dev_psel[i] = psel && (blk == i);
		end
	end

	//////////////////////////////////////////////////
	// Response mux

	always_comb begin
		prdata = '0;
		pready = 1'b0;
		pslverr = 1'b0;

		// At most one select is high
		for (int i = 0; i < mgmt_pkg::num_blocks; i++) begin
			if (dev_psel[i]) begin
				prdata = dev_prdata[i];
				pready = dev_pready[i];
				pslverr = dev_pslverr[i];
			end
		end

		// Unmapped block, answer with an error in the access phase
		if (psel && !hit) begin
			pready = penable;
			pslverr = penable;
		end
	end

endmodule

`default_nettype wire

//--- apb_reg_slice.sv
`timescale 1ns/1ps
`default_nettype none

module apb_reg_slice(
	input wire sys_clk,
	input wire rst,

	// Requester side
	input wire up_psel,
	input wire up_penable,
	input wire up_pwrite,
	input wire mgmt_pkg::apb_addr_t up_paddr,
	input wire mgmt_pkg::apb_data_t up_pwdata,
	output logic [15:0] up_prdata,
	output logic up_pready,
	output logic up_pslverr,

	// Device side
	output logic dn_psel,
	output logic dn_penable,
	output logic dn_pwrite,
	output mgmt_pkg::apb_addr_t dn_paddr,
	output mgmt_pkg::apb_data_t dn_pwdata,
	input wire mgmt_pkg::apb_data_t dn_prdata,
	input wire dn_pready,
	input wire dn_pslverr
);

	// Downstream access finishing in this cycle
	logic dn_done;
	assign dn_done = dn_psel && dn_penable && dn_pready;

	// Control half of the request, one cycle late
	// A finished access is dropped at once so it is not repeated
	// while the requester still holds its old request
	always_ff @(posedge sys_clk) begin
		if (rst) begin
			dn_psel <= 1'b0;
			dn_penable <= 1'b0;
		end else if (dn_done) begin
			dn_psel <= 1'b0;
			dn_penable <= 1'b0;
		end else begin
			dn_psel <= up_psel;
			dn_penable <= up_psel && up_penable;
		end
	end

	// Payload half of the request
	always_ff @(posedge sys_clk) begin
		dn_pwrite <= up_pwrite;
		dn_paddr <= up_paddr;
		dn_pwdata <= up_pwdata;
	end

	// Response goes straight back
	// pready only counts once the devices see the access phase
	assign up_prdata = dn_prdata;
	assign up_pready = dn_pready && dn_penable;
	assign up_pslverr = dn_pslverr;

endmodule

`default_nettype wire

//--- mgmt_pkg.sv
`default_nettype none

package mgmt_pkg;

	//////////////////////////////////////////////////
	// Bus geometry

	localparam int apb_addr_bits = 24;
	localparam int apb_data_bits = 16;

	// Device blocks are 0x400 bytes each
	localparam int block_addr_bits = 10;
	localparam int num_blocks = 2;

	typedef logic [apb_addr_bits-1:0] apb_addr_t;
	typedef logic [block_addr_bits-1:0] dev_addr_t;
	typedef logic [apb_addr_bits-block_addr_bits-1:0] blk_sel_t;
	typedef logic [apb_data_bits-1:0] apb_data_t;

	//////////////////////////////////////////////////
	// System information block

	typedef logic [31:0] idcode_t;
	typedef logic [15:0] tach_count_t;

	localparam dev_addr_t reg_idcode_lo = 10'h000;
	localparam dev_addr_t reg_idcode_hi = 10'h002;
	localparam dev_addr_t reg_fan0 = 10'h004;
	localparam dev_addr_t reg_fan1 = 10'h006;
	localparam dev_addr_t reg_scratch = 10'h008;

	// Tach gate window, in sys_clk cycles
	localparam int tach_window_cycles = 2000;
	typedef logic [$clog2(tach_window_cycles)-1:0] window_cnt_t;

	//////////////////////////////////////////////////
	// Front panel SPI block

	localparam dev_addr_t reg_fp_ctrl = 10'h000;
	localparam dev_addr_t reg_fp_data = 10'h002;
	localparam dev_addr_t reg_fp_status = 10'h004;

	// sys_clk cycles per SCK half period
	localparam int spi_clk_div = 4;
	typedef logic [$clog2(spi_clk_div)-1:0] spi_div_t;

	typedef logic [7:0] spi_byte_t;
	typedef logic [2:0] spi_bit_t;

	typedef enum logic [1:0] {idle, shift_low, shift_high, done_st} spi_state_t;

endpackage

`default_nettype wire
